// ==== verilog/rp_consts.svh ====
`ifndef RP_CONSTS_SVH
`define RP_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////////////////////

`define RP_ADC_IN_W   16            // raw ADC pins, low 2 bits unused
`define RP_ADW        14            // converted ADC sample
`define RP_DAC_W      14            // DAC bus code
`define RP_SUM_W      15            // asg + pid before saturation

// cycles held in reset after lock
`define RP_RST_MAX    64

////////////////////////////////////////////////////////////////////////////
// housekeeping bus
////////////////////////////////////////////////////////////////////////////

`define RP_SYS_AW     20
`define RP_SYS_DW     32

`define RP_HK_ID_VAL  32'h5250_0001 // fixed id word

// register map, byte addresses
`define RP_ADDR_ID    20'h0_0000
`define RP_ADDR_LOOP  20'h0_000C    // digital loopback bits
`define RP_ADDR_LED   20'h0_0030

`endif

// ==== verilog/rp_pkg.sv ====
`include "rp_consts.svh"

package rp_pkg;

  //////////////////////////////////////////////////////////////////////////
  // sample types
  //////////////////////////////////////////////////////////////////////////

  // two's complement ADC / generator sample
  typedef logic signed [`RP_ADW-1:0] adc_sample_t;

  // offset binary, negative slope, as the DAC pins expect it
  typedef logic [`RP_DAC_W-1:0] dac_code_t;

  //////////////////////////////////////////////////////////////////////////
  // state and opcode enums
  //////////////////////////////////////////////////////////////////////////

  // post-lock reset sequencer
  typedef enum logic [1:0] {
    RST_WAIT_LOCK,  // pll not locked yet
    RST_COUNT,      // lock seen, counting
    RST_RUN         // datapath out of reset
  } rst_state_e;

  // housekeeping register select, decoded from bus address
  typedef enum logic [1:0] {
    HK_ID,
    HK_LOOP,
    HK_LED,
    HK_NONE         // unmapped address
  } hk_reg_e;

endpackage

// ==== verilog/rp_reset_seq.sv ====
`include "rp_consts.svh"

module rp_reset_seq (
  input  logic adc_clk,
  input  logic rst_n_i,       // board reset
  input  logic pll_locked_i,
  output logic dp_rst_n_o,    // datapath reset, active low
  output logic dac_rst_o      // DAC reset, active high
);

  localparam int CNT_W = $clog2(`RP_RST_MAX + 1);

  rp_pkg::rst_state_e state_q;
  logic [CNT_W-1:0]   cnt_q;
  logic               lock_q;   // lock, one cycle back
  logic               lock_rise;

  assign lock_rise = pll_locked_i & ~lock_q;

  //////////////////////////////////////////////////////////////////////////
  // lock FSM and counter
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= rp_pkg::RST_WAIT_LOCK;
      cnt_q   <= '0;
      lock_q  <= 1'b0;
    end else begin
      lock_q <= pll_locked_i;
      case (state_q)
        rp_pkg::RST_WAIT_LOCK: begin
          cnt_q <= '0;
          if (lock_rise)                       // first high sample of lock
            state_q <= rp_pkg::RST_COUNT;
        end
        rp_pkg::RST_COUNT: begin
          if (!pll_locked_i) begin             // lost it mid count
            state_q <= rp_pkg::RST_WAIT_LOCK;
            cnt_q   <= '0;
          end else if (cnt_q == CNT_W'(`RP_RST_MAX)) begin
            state_q <= rp_pkg::RST_RUN;
            cnt_q   <= '0;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        rp_pkg::RST_RUN: begin
          if (!pll_locked_i)
            state_q <= rp_pkg::RST_WAIT_LOCK;  // start over on next lock
        end
        default: state_q <= rp_pkg::RST_WAIT_LOCK;
      endcase
    end
  end

  // registered reset outputs, both follow the same condition
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dp_rst_n_o <= 1'b0;
      dac_rst_o  <= 1'b1;
    end else begin
      dp_rst_n_o <=  (state_q == rp_pkg::RST_RUN) &  pll_locked_i;
      dac_rst_o  <= ~((state_q == rp_pkg::RST_RUN) & pll_locked_i);
    end
  end

  // count stays inside its range over the whole sequence
  a_cnt_range: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    cnt_q <= CNT_W'(`RP_RST_MAX));

endmodule

// ==== verilog/rp_hk_regs.sv ====
`include "rp_consts.svh"

module rp_hk_regs (
  input  logic                  adc_clk,
  input  logic                  rst_n_i,
  // system bus
  input  logic [`RP_SYS_AW-1:0] sys_addr_i,
  input  logic [`RP_SYS_DW-1:0] sys_wdata_i,
  input  logic                  sys_wen_i,
  input  logic                  sys_ren_i,
  output logic [`RP_SYS_DW-1:0] sys_rdata_o,
  output logic                  sys_ack_o,
  output logic                  sys_err_o,
  // configuration out
  output logic [1:0]            digital_loop_o,
  output logic [7:0]            led_o
);

  rp_pkg::hk_reg_e reg_sel;
  logic            access;     // any strobe this cycle
  logic [1:0]      loop_q;
  logic [7:0]      led_q;

  assign access = sys_wen_i | sys_ren_i;

  //////////////////////////////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (sys_addr_i)
      `RP_ADDR_ID:   reg_sel = rp_pkg::HK_ID;
      `RP_ADDR_LOOP: reg_sel = rp_pkg::HK_LOOP;
      `RP_ADDR_LED:  reg_sel = rp_pkg::HK_LED;
      default:       reg_sel = rp_pkg::HK_NONE;
    endcase
  end

  //////////////////////////////////////////////////////////////////////////
  // registers and handshake
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      loop_q    <= '0;
      led_q     <= '0;
      sys_ack_o <= 1'b0;
      sys_err_o <= 1'b0;
    end else begin
      sys_ack_o <= access;                                // one cycle after strobe
      sys_err_o <= access & (reg_sel == rp_pkg::HK_NONE); // unmapped
      if (sys_wen_i) begin
        case (reg_sel)
          rp_pkg::HK_LOOP: loop_q <= sys_wdata_i[1:0];
          rp_pkg::HK_LED:  led_q  <= sys_wdata_i[7:0];
          default: ;                                      // id is read only
        endcase
      end
    end
  end

  // read data, only meaningful with ack
  always_ff @(posedge adc_clk) begin
    if (sys_ren_i) begin
      case (reg_sel)
        rp_pkg::HK_ID:   sys_rdata_o <= `RP_HK_ID_VAL;
        rp_pkg::HK_LOOP: sys_rdata_o <= {{(`RP_SYS_DW-2){1'b0}}, loop_q};
        rp_pkg::HK_LED:  sys_rdata_o <= {{(`RP_SYS_DW-8){1'b0}}, led_q};
        default:         sys_rdata_o <= '0;
      endcase
    end
  end

  assign digital_loop_o = loop_q;  // [0] dac->adc, [1] adc->dac
  assign led_o          = led_q;

  // no spurious ack, every one answers a strobe from the cycle before
  a_ack_strobe: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    sys_ack_o |-> $past(sys_wen_i || sys_ren_i));

endmodule

// ==== verilog/rp_adc_front.sv ====
`include "rp_consts.svh"

module rp_adc_front (
  input  logic                    adc_clk,
  input  logic                    rst_n_i,
  input  logic [`RP_ADC_IN_W-1:0] adc_dat_i,  // raw pins
  input  logic                    loop_i,     // digital loop 0
  input  rp_pkg::adc_sample_t     dac_sat_i,  // saturated DAC sample
  output rp_pkg::adc_sample_t     adc_dat_o
);

  logic [`RP_ADW-1:0]  adc_raw;   // top bits only
  rp_pkg::adc_sample_t adc_conv;  // two's complement
  rp_pkg::adc_sample_t adc_nxt;

  //////////////////////////////////////////////////////////////////////////
  // slicing and conversion
  //////////////////////////////////////////////////////////////////////////

  // 14-bit converter sits on the upper pins
  assign adc_raw = adc_dat_i[`RP_ADC_IN_W-1 -: `RP_ADW];

  // unsigned, negative slope -> two's complement
  // keep the msb, flip the magnitude bits
  assign adc_conv = {adc_raw[`RP_ADW-1], ~adc_raw[`RP_ADW-2:0]};

  // loop 0 replaces the converter with the DAC sample
  assign adc_nxt = loop_i ? dac_sat_i : adc_conv;

  //////////////////////////////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      adc_dat_o <= '0;
    end else begin
      adc_dat_o <= adc_nxt;  // one cycle latency either way
    end
  end

endmodule

// ==== verilog/rp_dac_back.sv ====
`include "rp_consts.svh"

module rp_dac_back (
  input  logic                adc_clk,
  input  logic                rst_n_i,
  input  rp_pkg::adc_sample_t asg_dat_i,   // generator sample
  input  rp_pkg::adc_sample_t pid_dat_i,   // controller sample
  input  rp_pkg::adc_sample_t adc_dat_i,   // registered ADC sample
  input  logic                loop_i,      // digital loop 1
  output rp_pkg::adc_sample_t dac_sat_o,   // saturated sample before the register
  output rp_pkg::dac_code_t   dac_dat_o
);

  localparam int SMAX =  (2 ** (`RP_ADW - 1)) - 1;
  localparam int SMIN = -(2 ** (`RP_ADW - 1));

  logic signed [`RP_SUM_W-1:0] dac_sum;
  logic                        ovf;       // sum outside 14-bit range
  rp_pkg::adc_sample_t         out_sel;
  rp_pkg::dac_code_t           dac_nxt;
  int                          sum_full;  // full precision sum of the inputs

  //////////////////////////////////////////////////////////////////////////
  // sum and saturation
  //////////////////////////////////////////////////////////////////////////

  // both signed so the sum sign extends
  assign dac_sum = asg_dat_i + pid_dat_i;

  // top two bits differ -> overflow
  assign ovf = dac_sum[`RP_SUM_W-1] ^ dac_sum[`RP_SUM_W-2];

  // clamp to the extreme of the sum sign
  assign dac_sat_o = ovf ? {dac_sum[`RP_SUM_W-1], {(`RP_DAC_W-1){~dac_sum[`RP_SUM_W-1]}}}
                         : dac_sum[`RP_DAC_W-1:0];

  //////////////////////////////////////////////////////////////////////////
  // loopback and offset conversion
  //////////////////////////////////////////////////////////////////////////

  // loop 1 sends the ADC sample straight out
  assign out_sel = loop_i ? adc_dat_i : dac_sat_o;

  // back to offset form with negative slope
  assign dac_nxt = {out_sel[`RP_DAC_W-1], ~out_sel[`RP_DAC_W-2:0]};

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dac_dat_o <= '0;
    end else begin
      dac_dat_o <= dac_nxt;
    end
  end

  // exact sum taken straight from the ports
  assign sum_full = int'(asg_dat_i) + int'(pid_dat_i);

  // in range sums pass through untouched
  a_sat_exact: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    ((sum_full >= SMIN) && (sum_full <= SMAX)) |-> (int'(dac_sat_o) == sum_full));

endmodule

// ==== verilog/rp_analog_top.sv ====
`include "rp_consts.svh"

module rp_analog_top (
  input  logic                    adc_clk,
  input  logic                    rst_n_i,       // board reset
  input  logic                    pll_locked_i,
  // ADC
  input  logic [`RP_ADC_IN_W-1:0] adc_dat_i,
  // generator and controller samples
  input  rp_pkg::adc_sample_t     asg_dat_i,
  input  rp_pkg::adc_sample_t     pid_dat_i,
  // system bus
  input  logic [`RP_SYS_AW-1:0]   sys_addr_i,
  input  logic [`RP_SYS_DW-1:0]   sys_wdata_i,
  input  logic                    sys_wen_i,
  input  logic                    sys_ren_i,
  output logic [`RP_SYS_DW-1:0]   sys_rdata_o,
  output logic                    sys_ack_o,
  output logic                    sys_err_o,
  // DAC
  output rp_pkg::dac_code_t       dac_dat_o,
  output logic                    dac_rst_o,
  // LED
  output logic [7:0]              led_o
);

  logic                dp_rst_n;      // datapath reset, after lock
  logic [1:0]          digital_loop;
  rp_pkg::adc_sample_t adc_dat;
  rp_pkg::adc_sample_t dac_sat;

  ////////////////////////////////////////////////////////////////////////////
  // reset and housekeeping
  ////////////////////////////////////////////////////////////////////////////

  rp_reset_seq i_rst (
    .adc_clk      (adc_clk     ),
    .rst_n_i      (rst_n_i     ),
    .pll_locked_i (pll_locked_i),
    .dp_rst_n_o   (dp_rst_n    ),
    .dac_rst_o    (dac_rst_o   )
  );

  rp_hk_regs i_hk (
    .adc_clk        (adc_clk     ),
    .rst_n_i        (dp_rst_n    ),
    .sys_addr_i     (sys_addr_i  ),
    .sys_wdata_i    (sys_wdata_i ),
    .sys_wen_i      (sys_wen_i   ),
    .sys_ren_i      (sys_ren_i   ),
    .sys_rdata_o    (sys_rdata_o ),
    .sys_ack_o      (sys_ack_o   ),
    .sys_err_o      (sys_err_o   ),
    .digital_loop_o (digital_loop),
    .led_o          (led_o       )
  );

  ////////////////////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////////////////////

  rp_adc_front i_adc (
    .adc_clk   (adc_clk        ),
    .rst_n_i   (dp_rst_n       ),
    .adc_dat_i (adc_dat_i      ),
    .loop_i    (digital_loop[0]),  // dac -> adc
    .dac_sat_i (dac_sat        ),
    .adc_dat_o (adc_dat        )
  );

  rp_dac_back i_dac (
    .adc_clk   (adc_clk        ),
    .rst_n_i   (dp_rst_n       ),
    .asg_dat_i (asg_dat_i      ),
    .pid_dat_i (pid_dat_i      ),
    .adc_dat_i (adc_dat        ),
    .loop_i    (digital_loop[1]),  // adc -> dac
    .dac_sat_o (dac_sat        ),
    .dac_dat_o (dac_dat_o      )
  );

endmodule

// ==== tests/tb_analog_top.sv ====
`include "rp_consts.svh"

module tb_analog_top;

  localparam int CLK_HALF   = 20;
  localparam int MAX_CYCLES = 3000;                     // ~2x the full test length
  localparam int SMAX       = (1 << (`RP_ADW - 1)) - 1;
  localparam int SMIN       = -(1 << (`RP_ADW - 1));

  logic                    adc_clk;
  logic                    rst_n_i;
  logic                    pll_locked_i;
  logic [`RP_ADC_IN_W-1:0] adc_dat_i;
  rp_pkg::adc_sample_t     asg_dat_i;
  rp_pkg::adc_sample_t     pid_dat_i;
  logic [`RP_SYS_AW-1:0]   sys_addr_i;
  logic [`RP_SYS_DW-1:0]   sys_wdata_i;
  logic                    sys_wen_i;
  logic                    sys_ren_i;
  logic [`RP_SYS_DW-1:0]   sys_rdata_o;
  logic                    sys_ack_o;
  logic                    sys_err_o;
  rp_pkg::dac_code_t       dac_dat_o;
  logic                    dac_rst_o;
  logic [7:0]              led_o;

  int         seed;
  int         cycle_cnt;
  bit         check_en;      // compare process armed
  logic [1:0] loop_model;    // loop bits as last written
  int         asg_h [2];     // [0] last edge and [1] the edge before
  int         pid_h [2];
  int         adcu_h [2];    // unsigned raw top ADC bits

  rp_analog_top dut0 (.*);

  always #CLK_HALF adc_clk = ~adc_clk;

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic int clamp_sum(input int s);
    if (s > SMAX) return SMAX;
    if (s < SMIN) return SMIN;
    return s;
  endfunction

  // expected DAC code from loop bits and two edges of input history
  function automatic logic [`RP_DAC_W-1:0] ref_dac(input logic [1:0] loop, input int asg0,
      input int pid0, input int asg1, input int pid1, input int adcu1);
    int v;
    int code;
    if (loop[1] && loop[0])
      v = clamp_sum(asg1 + pid1);    // sat value goes round through the ADC reg
    else if (loop[1])
      v = SMAX - adcu1;              // negative slope raw -> signed
    else
      v = clamp_sum(asg0 + pid0);
    code = SMAX - v;                 // signed -> offset with negative slope
    return code[`RP_DAC_W-1:0];
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // checks and failure
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp) begin
      $display("Fail %s exp 0x%h got 0x%h", name, exp, got);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  // history as the DUT flops saw it
  always @(posedge adc_clk) begin
    asg_h[1]  = asg_h[0];
    pid_h[1]  = pid_h[0];
    adcu_h[1] = adcu_h[0];
    asg_h[0]  = int'(asg_dat_i);
    pid_h[0]  = int'(pid_dat_i);
    adcu_h[0] = int'(adc_dat_i[`RP_ADC_IN_W-1 -: `RP_ADW]);
  end

  // dac_dat_o is stable mid cycle
  always @(negedge adc_clk) begin
    if (check_en)
      check_val("dac_dat_o",
                32'(ref_dac(loop_model, asg_h[0], pid_h[0], asg_h[1], pid_h[1], adcu_h[1])),
                32'(dac_dat_o));
  end

  always @(posedge adc_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES)
      abort_run("timeout, the tests did not finish within the cycle limit");
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge adc_clk);
    #2;                              // drive just after the edge
  endtask

  task automatic drive_random(input int n);
    int r;
    repeat (n) begin
      next_cycle();
      r = $random(seed);
      asg_dat_i = r[`RP_ADW-1:0];
      r = $random(seed);
      pid_dat_i = r[`RP_ADW-1:0];
      r = $random(seed);
      adc_dat_i = r[`RP_ADC_IN_W-1:0];
    end
  endtask

  task automatic drive_pair(input int a, input int b);
    next_cycle();
    asg_dat_i = a[`RP_ADW-1:0];
    pid_dat_i = b[`RP_ADW-1:0];
  endtask

  // one strobe with its ack next cycle and quiet again after
  task automatic bus_access(input logic wr, input logic [`RP_SYS_AW-1:0] addr,
      input logic [`RP_SYS_DW-1:0] wdata, input logic exp_err,
      input logic [`RP_SYS_DW-1:0] exp_rdata);
    sys_addr_i  = addr;
    sys_wdata_i = wdata;
    sys_wen_i   = wr;
    sys_ren_i   = ~wr;
    next_cycle();
    sys_wen_i = 1'b0;
    sys_ren_i = 1'b0;
    check_val("sys_ack_o", 32'(1'b1), 32'(sys_ack_o));
    check_val("sys_err_o", 32'(exp_err), 32'(sys_err_o));
    if (!wr)
      check_val("sys_rdata_o", exp_rdata, sys_rdata_o);
    next_cycle();
    check_val("sys_ack_o", 32'(1'b0), 32'(sys_ack_o));  // ack only follows a strobe
  endtask

  // cycles from the lock edge until dac_rst_o falls
  task automatic measure_release();
    int n;
    n = 0;
    next_cycle();                    // this edge samples lock high
    while (dac_rst_o && n <= `RP_RST_MAX + 3) begin
      next_cycle();
      n++;
    end
    if (n < `RP_RST_MAX + 1 || n > `RP_RST_MAX + 3)
      abort_run($sformatf("dac_rst_o released %0d cycles after lock, outside the window", n));
  endtask

  task automatic set_loop(input logic [1:0] v);
    check_en = 1'b0;                 // path in transition
    bus_access(1'b1, `RP_ADDR_LOOP, 32'(v), 1'b0, '0);
    loop_model = v;
    drive_random(3);                 // refill history
    check_en = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed         = 23817;
    cycle_cnt    = 0;
    check_en     = 1'b0;
    loop_model   = 2'b00;
    adc_clk      = 1'b0;
    rst_n_i      = 1'b0;
    pll_locked_i = 1'b0;
    adc_dat_i    = '0;
    asg_dat_i    = '0;
    pid_dat_i    = '0;
    sys_addr_i   = '0;
    sys_wdata_i  = '0;
    sys_wen_i    = 1'b0;
    sys_ren_i    = 1'b0;

    repeat (8) @(posedge adc_clk);
    #2 rst_n_i = 1'b1;

    // DAC stays in reset without lock
    repeat (10) begin
      next_cycle();
      check_val("dac_rst_o", 32'(1'b1), 32'(dac_rst_o));
    end
    pll_locked_i = 1'b1;
    measure_release();

    bus_access(1'b1, `RP_ADDR_LED, 32'h0000_003C, 1'b0, '0);
    check_val("led_o", 32'h0000_003C, 32'(led_o));

    // lose lock so reset comes back then relock
    pll_locked_i = 1'b0;
    repeat (2) next_cycle();
    check_val("dac_rst_o", 32'(1'b1), 32'(dac_rst_o));
    sys_addr_i = 20'h0_0044;         // unmapped read while held in reset
    sys_ren_i  = 1'b1;
    next_cycle();
    sys_ren_i  = 1'b0;
    check_val("sys_ack_o", 32'h0, 32'(sys_ack_o));
    check_val("sys_err_o", 32'h0, 32'(sys_err_o));
    repeat (4) next_cycle();
    pll_locked_i = 1'b1;
    measure_release();

    // led and DAC cleared by the datapath reset
    check_val("led_o", 32'h0, 32'(led_o));
    check_val("dac_dat_o", 32'h0, 32'(dac_dat_o));

    // register map
    bus_access(1'b0, `RP_ADDR_ID, '0, 1'b0, `RP_HK_ID_VAL);
    bus_access(1'b0, `RP_ADDR_LOOP, '0, 1'b0, 32'h0);
    bus_access(1'b1, `RP_ADDR_LED, 32'hFFFF_FFA5, 1'b0, '0);
    check_val("led_o", 32'h0000_00A5, 32'(led_o));
    bus_access(1'b0, `RP_ADDR_LED, '0, 1'b0, 32'h0000_00A5);
    bus_access(1'b1, 20'h0_0044, 32'h0000_00FF, 1'b1, '0);      // unmapped
    bus_access(1'b0, 20'h0_0044, '0, 1'b1, 32'h0);
    bus_access(1'b1, `RP_ADDR_ID, 32'hDEAD_BEEF, 1'b0, '0);     // id is read only
    bus_access(1'b0, `RP_ADDR_ID, '0, 1'b0, `RP_HK_ID_VAL);
    bus_access(1'b0, `RP_ADDR_LED, '0, 1'b0, 32'h0000_00A5);
    check_val("led_o", 32'h0000_00A5, 32'(led_o));

    // normal path then saturation corners
    drive_random(3);
    check_en = 1'b1;
    drive_random(500);
    drive_pair(SMAX, SMAX);
    drive_pair(SMIN, SMIN);
    drive_pair(SMAX, SMIN);
    drive_pair(SMIN, SMAX);
    drive_pair(5000, 4000);
    drive_pair(-5000, -4000);
    drive_pair(SMAX, 1);
    drive_pair(SMIN, -1);
    drive_pair(100, -200);
    drive_random(20);

    set_loop(2'b10);                 // ADC -> DAC
    drive_random(300);
    set_loop(2'b11);                 // sum -> ADC -> DAC
    drive_random(300);
    set_loop(2'b01);                 // DAC -> ADC only
    drive_random(100);
    bus_access(1'b0, `RP_ADDR_LOOP, '0, 1'b0, 32'h0000_0001);

    check_en = 1'b0;
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+verilog
verilog/rp_pkg.sv
verilog/rp_reset_seq.sv
verilog/rp_hk_regs.sv
verilog/rp_adc_front.sv
verilog/rp_dac_back.sv
verilog/rp_analog_top.sv
tests/tb_analog_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f \
  --top-module tb_analog_top \
  -o tb_analog_top

# exit status is nonzero when the testbench ends in $fatal
./obj_dir/tb_analog_top
